// File: logic/n64_io_config.svh
// Build constants for the console I/O glue
// Download kinds, address widths, cartridge base and aspect table
`ifndef N64_IO_CONFIG_SVH
`define N64_IO_CONFIG_SVH

// Low six bits of the loader index
`define N64IO_IDX_PIF 0
`define N64IO_IDX_N64 1
`define N64IO_IDX_GB 2

// Handheld cartridge byte offset in SDRAM
`define N64IO_CARTGB_START 8388608

`define N64IO_SDRAM_AW 27
`define N64IO_PIF_AW 10

// Core aspect pairs, one per crop setting (none, 8, 12 lines)
`define N64IO_AR_NTSC_X0 512
`define N64IO_AR_NTSC_Y0 381
`define N64IO_AR_NTSC_X1 1280
`define N64IO_AR_NTSC_Y1 889
`define N64IO_AR_NTSC_X2 2560
`define N64IO_AR_NTSC_Y2 1714
`define N64IO_AR_PAL_X0 512
`define N64IO_AR_PAL_Y0 387
`define N64IO_AR_PAL_X1 1024
`define N64IO_AR_PAL_Y1 731
`define N64IO_AR_PAL_X2 2048
`define N64IO_AR_PAL_Y2 1419
`define N64IO_AR_DEF_X 4
`define N64IO_AR_DEF_Y 3

`endif

// File: logic/n64_io_pkg.sv
// Shared types for the console I/O glue
// Loader words, memory words, addresses and video settings

`include "n64_io_config.svh"

package n64_io_pkg;

	typedef logic [15:0] half_t;
	typedef logic [31:0] word_t;

	// Byte address on the SDRAM side, word address on the boot ROM side
	typedef logic [`N64IO_SDRAM_AW-1:0] sdram_addr_t;
	typedef logic [`N64IO_PIF_AW-1:0] pif_addr_t;

	typedef logic [5:0] dl_kind_t;

	// Vertical crop, value 3 is unused
	typedef enum logic [1:0] {
		CROP_NONE = 2'd0,
		CROP_8 = 2'd1,
		CROP_12 = 2'd2
	} crop_t;

	typedef enum logic [1:0] {
		AR_ORIGINAL = 2'd0,
		AR_FULL = 2'd1,
		AR_CUSTOM1 = 2'd2,
		AR_CUSTOM2 = 2'd3
	} aspect_mode_t;

	typedef logic [12:0] ar_size_t;
	typedef logic [1:0] pad_index_t;

endpackage

// File: logic/halfword_packer.sv
// Two-halfword to 32-bit word packer with a held write request
`timescale 1ns/1ns

module halfword_packer import n64_io_pkg::*; #(
	parameter type addr_t = pif_addr_t,
	parameter bit SWAP_BYTES = 1'b0
) (
	input logic clk_1x,
	input logic reset,
	input logic enable,
	input logic wr,
	input logic addr_bit1,
	input addr_t in_addr,
	input half_t in_data,
	input logic out_ready,
	output logic out_valid,
	output addr_t out_addr,
	output word_t out_data
);

	half_t half_in;
	half_t first_half;
	half_t second_half;
	logic strobe;

	// Strobes are ignored while a word waits for its handshake
	assign strobe = enable & wr & ~out_valid;

	// Boot ROM images come byte swapped
	assign half_in = SWAP_BYTES ? {in_data[7:0], in_data[15:8]} : in_data;

	// First half lands high in boot ROM order, low in cartridge order
	assign out_data = SWAP_BYTES ? {first_half, second_half} : {second_half, first_half};

	always_ff @(posedge clk_1x) begin
		if (strobe && !addr_bit1) begin
			first_half <= half_in;
			out_addr <= in_addr;
		end
		if (strobe && addr_bit1) begin
			second_half <= half_in;
		end
	end

	// Request rises after the second half and drops on acceptance
	always_ff @(posedge clk_1x) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (strobe && addr_bit1) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

endmodule

// File: logic/ioctl_loader.sv
// Host download decoder
// Feeds the boot ROM and handheld cartridge packers, flags the ROM copy
`timescale 1ns/1ns

`include "n64_io_config.svh"

module ioctl_loader import n64_io_pkg::*; (
	input logic clk_1x,
	input logic reset,
	input logic ioctl_download,
	input logic [7:0] ioctl_index,
	input sdram_addr_t ioctl_addr,
	input half_t ioctl_dout,
	input logic ioctl_wr,
	input logic pif_ready,
	input logic mem_ready,
	output logic ioctl_wait,
	output logic pif_valid,
	output pif_addr_t pif_addr,
	output word_t pif_data,
	output logic mem_valid,
	output sdram_addr_t mem_addr,
	output word_t mem_data,
	output logic romcopy_start,
	output sdram_addr_t romcopy_size,
	output logic cart_loaded,
	output logic cart_n64_download,
	output logic cart_gb_download
);

	localparam sdram_addr_t CARTGB_BASE = sdram_addr_t'(`N64IO_CARTGB_START);

	dl_kind_t dl_kind;
	logic pif_download;
	logic download_d;
	pif_addr_t pif_in_addr;
	sdram_addr_t cart_in_addr;

	assign dl_kind = ioctl_index[5:0];

	// Index bit 6 selects the upper half of the boot ROM
	assign pif_in_addr = {ioctl_index[6], ioctl_addr[10:2]};
	assign cart_in_addr = ioctl_addr + CARTGB_BASE;

	// Hold off the host while either word is still in flight
	assign ioctl_wait = pif_valid | mem_valid;

	// ============================================================
	// Download kind flags and ROM copy trigger
	// ============================================================
	always_ff @(posedge clk_1x) begin
		if (reset) begin
			pif_download <= 1'b0;
			cart_n64_download <= 1'b0;
			cart_gb_download <= 1'b0;
			download_d <= 1'b0;
			romcopy_start <= 1'b0;
			cart_loaded <= 1'b0;
		end else begin
			pif_download <= ioctl_download & (dl_kind == dl_kind_t'(`N64IO_IDX_PIF));
			cart_n64_download <= ioctl_download & (dl_kind == dl_kind_t'(`N64IO_IDX_N64));
			cart_gb_download <= ioctl_download & (dl_kind == dl_kind_t'(`N64IO_IDX_GB));
			download_d <= ioctl_download;
			romcopy_start <= download_d & ~ioctl_download &
				(dl_kind == dl_kind_t'(`N64IO_IDX_N64));
			// Sticky until reset
			if (cart_n64_download) begin
				cart_loaded <= 1'b1;
			end
		end
	end

	// Final address of the main cartridge gives the copy length
	always_ff @(posedge clk_1x) begin
		if (download_d && !ioctl_download) begin
			romcopy_size <= ioctl_addr;
		end
	end

	// ============================================================
	// Word packers
	// ============================================================
	halfword_packer #(.addr_t(pif_addr_t), .SWAP_BYTES(1'b1)) pif_packer (
		.clk_1x(clk_1x),
		.reset(reset),
		.enable(pif_download),
		.wr(ioctl_wr),
		.addr_bit1(ioctl_addr[1]),
		.in_addr(pif_in_addr),
		.in_data(ioctl_dout),
		.out_ready(pif_ready),
		.out_valid(pif_valid),
		.out_addr(pif_addr),
		.out_data(pif_data)
	);

	halfword_packer #(.addr_t(sdram_addr_t), .SWAP_BYTES(1'b0)) cart_packer (
		.clk_1x(clk_1x),
		.reset(reset),
		.enable(cart_gb_download),
		.wr(ioctl_wr),
		.addr_bit1(ioctl_addr[1]),
		.in_addr(cart_in_addr),
		.in_data(ioctl_dout),
		.out_ready(mem_ready),
		.out_valid(mem_valid),
		.out_addr(mem_addr),
		.out_data(mem_data)
	);

endmodule

// File: logic/backup_control.sv
// Backup memory load and save triggers, image use flag and user LED
`timescale 1ns/1ns

module backup_control import n64_io_pkg::*; (
	input logic clk_1x,
	input logic reset,
	input logic cart_n64_download,
	input logic cart_gb_download,
	input logic load_req,
	input logic save_req,
	input logic autosave_off,
	input logic osd_status,
	input logic img_mounted,
	input logic img_readonly,
	input logic img_size_nonzero,
	input logic bk_pending,
	output logic bk_load,
	output logic bk_save,
	output logic use_img,
	output logic led_user
);

	logic osd_status_d;
	logic n64_download_d;

	assign led_user = cart_n64_download | cart_gb_download | bk_pending;

	always_ff @(posedge clk_1x) begin
		if (reset) begin
			osd_status_d <= 1'b0;
			n64_download_d <= 1'b0;
			bk_load <= 1'b0;
			bk_save <= 1'b0;
			use_img <= 1'b0;
		end else begin
			osd_status_d <= osd_status;
			n64_download_d <= cart_n64_download;
			// Mount during a cartridge load pulls in the save image
			bk_load <= load_req | (cart_n64_download & img_mounted);
			// Autosave when the menu opens
			bk_save <= save_req | (osd_status & ~osd_status_d & ~autosave_off);
			if (cart_n64_download && !n64_download_d) begin
				use_img <= 1'b0;
			end
			if (img_mounted && img_size_nonzero && !img_readonly) begin
				use_img <= 1'b1;
			end
		end
	end

endmodule

// File: logic/aspect_ratio_select.sv
// HDMI aspect ratio selection
// Core ratio from video standard and crop, overridden by the aspect mode
`timescale 1ns/1ns

`include "n64_io_config.svh"

module aspect_ratio_select import n64_io_pkg::*; (
	input logic clk_1x,
	input logic reset,
	input logic is_pal,
	input logic fixed_blanks_off,
	input crop_t crop,
	input aspect_mode_t aspect_mode,
	output ar_size_t video_arx,
	output ar_size_t video_ary
);

	ar_size_t ar_core_x;
	ar_size_t ar_core_y;

	// ============================================================
	// Core ratio register
	// ============================================================
	always_ff @(posedge clk_1x) begin
		if (reset || fixed_blanks_off) begin
			ar_core_x <= ar_size_t'(`N64IO_AR_DEF_X);
			ar_core_y <= ar_size_t'(`N64IO_AR_DEF_Y);
		end else if (is_pal) begin
			case (crop)
				CROP_NONE: begin
					ar_core_x <= ar_size_t'(`N64IO_AR_PAL_X0);
					ar_core_y <= ar_size_t'(`N64IO_AR_PAL_Y0);
				end
				CROP_8: begin
					ar_core_x <= ar_size_t'(`N64IO_AR_PAL_X1);
					ar_core_y <= ar_size_t'(`N64IO_AR_PAL_Y1);
				end
				CROP_12: begin
					ar_core_x <= ar_size_t'(`N64IO_AR_PAL_X2);
					ar_core_y <= ar_size_t'(`N64IO_AR_PAL_Y2);
				end
				// Unused crop code keeps the last pair
				default: ;
			endcase
		end else begin
			case (crop)
				CROP_NONE: begin
					ar_core_x <= ar_size_t'(`N64IO_AR_NTSC_X0);
					ar_core_y <= ar_size_t'(`N64IO_AR_NTSC_Y0);
				end
				CROP_8: begin
					ar_core_x <= ar_size_t'(`N64IO_AR_NTSC_X1);
					ar_core_y <= ar_size_t'(`N64IO_AR_NTSC_Y1);
				end
				CROP_12: begin
					ar_core_x <= ar_size_t'(`N64IO_AR_NTSC_X2);
					ar_core_y <= ar_size_t'(`N64IO_AR_NTSC_Y2);
				end
				default: ;
			endcase
		end
	end

	// Other modes pass the custom ratio index to the scaler
	assign video_arx = (aspect_mode == AR_ORIGINAL) ? ar_core_x :
		ar_size_t'(aspect_mode) - ar_size_t'(1);
	assign video_ary = (aspect_mode == AR_ORIGINAL) ? ar_core_y : '0;

endmodule

// File: logic/snac_port_mux.sv
// Routes the serial line of the selected game pad to the user port
`timescale 1ns/1ns

module snac_port_mux import n64_io_pkg::*; (
	input logic clk_1x,
	input logic reset,
	input logic snac_on,
	input pad_index_t pad_index,
	input logic pad_data_out,
	input logic [6:0] user_in,
	output logic [6:0] user_out,
	output logic pad_data_in
);

	// Pin map
	// pad 0 on pin 1 (D-), pad 1 on pin 0 (D+)
	// pad 2 on pin 5, pad 3 on pin 4
	always_ff @(posedge clk_1x) begin
		if (reset) begin
			user_out <= '1;
			pad_data_in <= 1'b0;
		end else if (snac_on) begin
			case (pad_index)
				2'd0: begin
					user_out[1] <= pad_data_out;
					pad_data_in <= user_in[1];
				end
				2'd1: begin
					user_out[0] <= pad_data_out;
					pad_data_in <= user_in[0];
				end
				2'd2: begin
					user_out[5] <= pad_data_out;
					pad_data_in <= user_in[5];
				end
				default: begin
					user_out[4] <= pad_data_out;
					pad_data_in <= user_in[4];
				end
			endcase
			// Unused pins stay released
			user_out[2] <= 1'b1;
			user_out[3] <= 1'b1;
			user_out[6] <= 1'b1;
		end else begin
			// Open drain port, high lets the pins be read
			user_out <= '1;
		end
	end

endmodule

// File: logic/n64_io_top.sv
// Console I/O glue top level
// Loader streams, backup triggers, HDMI aspect and SNAC routing
`timescale 1ns/1ns

module n64_io_top import n64_io_pkg::*; (
	input logic clk_1x,
	input logic reset,
	input logic ioctl_download,
	input logic [7:0] ioctl_index,
	input sdram_addr_t ioctl_addr,
	input half_t ioctl_dout,
	input logic ioctl_wr,
	output logic ioctl_wait,
	output logic pif_valid,
	output pif_addr_t pif_addr,
	output word_t pif_data,
	input logic pif_ready,
	output logic mem_valid,
	output sdram_addr_t mem_addr,
	output word_t mem_data,
	input logic mem_ready,
	output logic romcopy_start,
	output sdram_addr_t romcopy_size,
	output logic cart_loaded,
	input logic load_req,
	input logic save_req,
	input logic autosave_off,
	input logic osd_status,
	input logic img_mounted,
	input logic img_readonly,
	input logic img_size_nonzero,
	input logic bk_pending,
	output logic bk_load,
	output logic bk_save,
	output logic use_img,
	output logic led_user,
	input logic is_pal,
	input logic fixed_blanks_off,
	input crop_t crop,
	input aspect_mode_t aspect_mode,
	output ar_size_t video_arx,
	output ar_size_t video_ary,
	input logic snac_on,
	input pad_index_t pad_index,
	input logic pad_data_out,
	input logic [6:0] user_in,
	output logic [6:0] user_out,
	output logic pad_data_in
);

	logic cart_n64_download;
	logic cart_gb_download;

	ioctl_loader loader (.*);

	backup_control backup (.*);

	aspect_ratio_select aspect (.*);

	snac_port_mux snac (.*);

endmodule

// File: sim/n64_io_tb.sv
// Testbench for the console I/O glue
// Loader streams, ROM copy, backup triggers, aspect table and SNAC pins
`timescale 1ns/1ns

`include "n64_io_config.svh"

module n64_io_tb import n64_io_pkg::*; ();

	logic clk_1x;
	logic reset;
	logic ioctl_download;
	logic [7:0] ioctl_index;
	sdram_addr_t ioctl_addr;
	half_t ioctl_dout;
	logic ioctl_wr;
	logic ioctl_wait;
	logic pif_valid;
	pif_addr_t pif_addr;
	word_t pif_data;
	logic pif_ready;
	logic mem_valid;
	sdram_addr_t mem_addr;
	word_t mem_data;
	logic mem_ready;
	logic romcopy_start;
	sdram_addr_t romcopy_size;
	logic cart_loaded;
	logic load_req;
	logic save_req;
	logic autosave_off;
	logic osd_status;
	logic img_mounted;
	logic img_readonly;
	logic img_size_nonzero;
	logic bk_pending;
	logic bk_load;
	logic bk_save;
	logic use_img;
	logic led_user;
	logic is_pal;
	logic fixed_blanks_off;
	crop_t crop;
	aspect_mode_t aspect_mode;
	ar_size_t video_arx;
	ar_size_t video_ary;
	logic snac_on;
	pad_index_t pad_index;
	logic pad_data_out;
	logic [6:0] user_in;
	logic [6:0] user_out;
	logic pad_data_in;

	// Expected words in arrival order
	pif_addr_t pif_exp_addr[$];
	word_t pif_exp_data[$];
	sdram_addr_t mem_exp_addr[$];
	word_t mem_exp_data[$];

	int pif_count = 0;
	int mem_count = 0;
	int romcopy_count = 0;
	int bk_load_count = 0;
	int bk_save_count = 0;
	int stall_len[16];
	logic stream_done;
	logic [15:0] lfsr_state = 16'd90;

	// Core pairs as x then y for crop none, 8 and 12 lines
	int ntsc_pairs[6] = '{`N64IO_AR_NTSC_X0, `N64IO_AR_NTSC_Y0, `N64IO_AR_NTSC_X1,
		`N64IO_AR_NTSC_Y1, `N64IO_AR_NTSC_X2, `N64IO_AR_NTSC_Y2};
	int pal_pairs[6] = '{`N64IO_AR_PAL_X0, `N64IO_AR_PAL_Y0, `N64IO_AR_PAL_X1,
		`N64IO_AR_PAL_Y1, `N64IO_AR_PAL_X2, `N64IO_AR_PAL_Y2};
	int pin_of_pad[4] = '{1, 0, 5, 4};

	n64_io_top uut (.*);

	initial begin
		clk_1x = 1'b0;
		forever #20 clk_1x = ~clk_1x;
	end

	// ============================================================
	// Failure reporting, LFSR and timing helpers
	// ============================================================
	task automatic stop_run();
		$display("TB FAILED");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string msg);
		$display("Fail at %0t ns: %s", $time, msg);
		stop_run();
	endtask

	task automatic report_problem(input string msg);
		$display("%s", msg);
		stop_run();
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	function automatic logic [31:0] random_bits(input int nbits);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < nbits; i++) begin
			value = {value[30:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
		return value;
	endfunction

	task automatic tick();
		@(posedge clk_1x);
		#5;
	endtask

	task automatic write_half(input sdram_addr_t addr, input half_t data);
		int waited;
		waited = 0;
		while (ioctl_wait) begin
			tick();
			waited++;
			if (waited > 200) report_problem("Timeout waiting for ioctl_wait to fall");
		end
		ioctl_addr = addr;
		ioctl_dout = data;
		ioctl_wr = 1'b1;
		tick();
		ioctl_wr = 1'b0;
	endtask

	task automatic wait_streams_idle();
		int waited;
		waited = 0;
		while (pif_exp_addr.size() != 0 || mem_exp_addr.size() != 0 || ioctl_wait) begin
			tick();
			waited++;
			if (waited > 500) report_problem("Timeout waiting for the write streams to drain");
		end
	endtask

	task automatic mount_image(input logic readonly);
		img_readonly = readonly;
		img_mounted = 1'b1;
		tick();
		img_mounted = 1'b0;
		tick();
		tick();
	endtask

	// ============================================================
	// Stream protocol and monitors
	// ============================================================
	pif_single: assert property (@(posedge clk_1x) disable iff (reset)
		pif_valid && pif_ready |=> !pif_valid)
		else report_problem("Boot ROM request stayed up after its handshake");
	mem_hold: assert property (@(posedge clk_1x) disable iff (reset)
		mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_data))
		else report_problem("Cartridge stream changed a word before it was accepted");
	mem_single: assert property (@(posedge clk_1x) disable iff (reset)
		mem_valid && mem_ready |=> !mem_valid)
		else report_problem("Cartridge request stayed up after its handshake");
	wr_blocked: assert property (@(posedge clk_1x) disable iff (reset) !(ioctl_wr && ioctl_wait))
		else report_problem("Loader wrote while ioctl_wait was high");

	// Scoreboard for both write streams and the trigger pulses
	always @(negedge clk_1x) begin
		if (!reset) begin
			if (pif_valid && pif_ready) begin
				assert (pif_exp_addr.size() > 0) else report_problem("Unexpected boot ROM word");
				assert (pif_addr == pif_exp_addr[0] && pif_data == pif_exp_data[0])
					else report_mismatch($sformatf("pif word %h at %h, expected %h at %h",
						pif_data, pif_addr, pif_exp_data[0], pif_exp_addr[0]));
				void'(pif_exp_addr.pop_front());
				void'(pif_exp_data.pop_front());
				pif_count++;
			end
			if (mem_valid && mem_ready) begin
				assert (mem_exp_addr.size() > 0) else report_problem("Unexpected cartridge word");
				assert (mem_addr == mem_exp_addr[0] && mem_data == mem_exp_data[0])
					else report_mismatch($sformatf("mem word %h at %h, expected %h at %h",
						mem_data, mem_addr, mem_exp_data[0], mem_exp_addr[0]));
				void'(mem_exp_addr.pop_front());
				void'(mem_exp_data.pop_front());
				mem_count++;
			end
			if (romcopy_start) romcopy_count++;
			if (bk_load) bk_load_count++;
			if (bk_save) bk_save_count++;
		end
	end

	// ============================================================
	// Test sequences
	// ============================================================
	task automatic boot_rom_download();
		sdram_addr_t a;
		half_t h0;
		half_t h1;
		ioctl_index = 8'h40;
		ioctl_download = 1'b1;
		tick();
		// Range crosses address bit 10
		for (int i = 0; i < 8; i++) begin
			a = sdram_addr_t'(32'h3F0 + i * 4);
			h0 = half_t'(random_bits(16));
			h1 = half_t'(random_bits(16));
			pif_exp_addr.push_back({1'b1, a[10:2]});
			pif_exp_data.push_back({h0[7:0], h0[15:8], h1[7:0], h1[15:8]});
			write_half(a, h0);
			write_half(a + 27'd2, h1);
		end
		wait_streams_idle();
		assert (pif_count == 8) else report_mismatch($sformatf("%0d pif words", pif_count));
		ioctl_download = 1'b0;
		tick();
	endtask

	task automatic apply_back_pressure();
		int k;
		k = 0;
		while (!stream_done) begin
			mem_ready = 1'b0;
			repeat (stall_len[k % 16]) tick();
			mem_ready = 1'b1;
			tick();
			k++;
			if (k > 500) report_problem("Timeout while throttling mem_ready");
		end
	endtask

	task automatic handheld_download();
		sdram_addr_t a;
		half_t h0;
		half_t h1;
		for (int k = 0; k < 16; k++) begin
			stall_len[k] = int'(random_bits(3));
		end
		ioctl_index = 8'h02;
		ioctl_download = 1'b1;
		stream_done = 1'b0;
		tick();
		assert (led_user) else report_mismatch("led_user low during handheld download");
		fork
			apply_back_pressure();
			begin
				for (int i = 0; i < 8; i++) begin
					a = sdram_addr_t'(32'h1000 + i * 4);
					h0 = half_t'(random_bits(16));
					h1 = half_t'(random_bits(16));
					mem_exp_addr.push_back(a + sdram_addr_t'(`N64IO_CARTGB_START));
					mem_exp_data.push_back({h1, h0});
					write_half(a, h0);
					write_half(a + 27'd2, h1);
				end
				wait_streams_idle();
				stream_done = 1'b1;
			end
		join
		assert (mem_count == 8) else report_mismatch($sformatf("%0d mem words", mem_count));
		ioctl_download = 1'b0;
		tick();
	endtask

	task automatic main_download();
		sdram_addr_t last;
		int waited;
		// Empty image is not used
		img_size_nonzero = 1'b0;
		mount_image(1'b0);
		img_size_nonzero = 1'b1;
		assert (!use_img && bk_load_count == 0) else report_mismatch("empty mount response");
		// Idle mount sets the image flag but loads nothing
		mount_image(1'b0);
		assert (use_img && bk_load_count == 0) else report_mismatch("idle mount response");
		assert (romcopy_count == 0 && !cart_loaded) else report_mismatch("early ROM copy state");
		ioctl_index = 8'h01;
		ioctl_download = 1'b1;
		repeat (3) tick();
		assert (led_user && cart_loaded && !use_img)
			else report_mismatch("led_user, cart_loaded or use_img at download start");
		mount_image(1'b1);
		assert (bk_load_count == 1 && !use_img) else report_mismatch("read-only mount response");
		mount_image(1'b0);
		assert (bk_load_count == 2 && use_img) else report_mismatch("writable mount response");
		for (int i = 0; i < 6; i++) begin
			last = sdram_addr_t'(32'h123400 + i * 2);
			write_half(last, half_t'(random_bits(16)));
		end
		ioctl_download = 1'b0;
		waited = 0;
		while (!romcopy_start) begin
			tick();
			waited++;
			if (waited > 20) report_problem("Timeout waiting for romcopy_start");
		end
		repeat (4) tick();
		assert (romcopy_count == 1)
			else report_mismatch($sformatf("%0d romcopy_start pulses", romcopy_count));
		assert (romcopy_size == last)
			else report_mismatch($sformatf("romcopy_size %h, expected %h", romcopy_size, last));
		assert (cart_loaded && !led_user) else report_mismatch("cart_loaded or led_user after load");
	endtask

	task automatic backup_triggers();
		save_req = 1'b1;
		tick();
		save_req = 1'b0;
		repeat (2) tick();
		assert (bk_save_count == 1) else report_mismatch("save_req response");
		autosave_off = 1'b1;
		osd_status = 1'b1;
		repeat (3) tick();
		osd_status = 1'b0;
		tick();
		assert (bk_save_count == 1) else report_mismatch("bk_save with autosave off");
		autosave_off = 1'b0;
		osd_status = 1'b1;
		repeat (3) tick();
		osd_status = 1'b0;
		tick();
		assert (bk_save_count == 2) else report_mismatch("menu open autosave response");
		load_req = 1'b1;
		tick();
		load_req = 1'b0;
		repeat (2) tick();
		assert (bk_load_count == 3) else report_mismatch("load_req response");
		bk_pending = 1'b1;
		tick();
		assert (led_user) else report_mismatch("led_user low with backup pending");
		bk_pending = 1'b0;
		tick();
		assert (!led_user) else report_mismatch("led_user high with nothing pending");
	endtask

	task automatic aspect_table();
		int sel;
		int exp_x;
		int exp_y;
		aspect_mode = AR_ORIGINAL;
		for (int p = 0; p < 2; p++) begin
			for (int c = 0; c < 4; c++) begin
				is_pal = p[0];
				crop = crop_t'(c[1:0]);
				repeat (2) tick();
				// Code 3 leaves the 12-line pair in place
				sel = (c == 3) ? 2 : c;
				exp_x = p[0] ? pal_pairs[2 * sel] : ntsc_pairs[2 * sel];
				exp_y = p[0] ? pal_pairs[2 * sel + 1] : ntsc_pairs[2 * sel + 1];
				assert (int'(video_arx) == exp_x && int'(video_ary) == exp_y)
					else report_mismatch($sformatf("ratio %0d:%0d, expected %0d:%0d",
						video_arx, video_ary, exp_x, exp_y));
			end
		end
		fixed_blanks_off = 1'b1;
		repeat (2) tick();
		assert (int'(video_arx) == `N64IO_AR_DEF_X && int'(video_ary) == `N64IO_AR_DEF_Y)
			else report_mismatch("ratio with fixed blanks off");
		fixed_blanks_off = 1'b0;
		for (int m = 1; m < 4; m++) begin
			aspect_mode = aspect_mode_t'(m[1:0]);
			tick();
			assert (int'(video_arx) == m - 1 && int'(video_ary) == 0)
				else report_mismatch($sformatf("mode %0d gives %0d:%0d", m, video_arx, video_ary));
		end
		aspect_mode = AR_ORIGINAL;
	endtask

	task automatic snac_routing();
		logic [6:0] pins_in;
		int pin;
		snac_on = 1'b1;
		for (int p = 0; p < 4; p++) begin
			for (int v = 0; v < 2; v++) begin
				pin = pin_of_pad[p];
				pad_index = pad_index_t'(p[1:0]);
				pad_data_out = v[0];
				pins_in = 7'(random_bits(7));
				user_in = pins_in;
				repeat (2) tick();
				assert (user_out[pin] == v[0] && pad_data_in == pins_in[pin])
					else report_mismatch($sformatf("pad %0d pin %0d out %b in %b",
						p, pin, user_out[pin], pad_data_in));
				assert (user_out[2] && user_out[3] && user_out[6])
					else report_mismatch($sformatf("unused pins low, user_out %b", user_out));
			end
		end
		snac_on = 1'b0;
		repeat (2) tick();
		assert (user_out == 7'h7F) else report_mismatch("user pins not released with SNAC off");
	endtask

	// ============================================================
	// Main sequence
	// ============================================================
	initial begin
		reset = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index = 8'h00;
		ioctl_addr = '0;
		ioctl_dout = '0;
		ioctl_wr = 1'b0;
		pif_ready = 1'b1;
		mem_ready = 1'b1;
		load_req = 1'b0;
		save_req = 1'b0;
		autosave_off = 1'b0;
		osd_status = 1'b0;
		img_mounted = 1'b0;
		img_readonly = 1'b0;
		img_size_nonzero = 1'b1;
		bk_pending = 1'b0;
		is_pal = 1'b0;
		fixed_blanks_off = 1'b0;
		crop = CROP_NONE;
		aspect_mode = AR_ORIGINAL;
		snac_on = 1'b0;
		pad_index = '0;
		pad_data_out = 1'b1;
		user_in = '1;
		stream_done = 1'b0;
		repeat (10) @(posedge clk_1x);
		#5;
		reset = 1'b0;
		assert (!pif_valid && !mem_valid && !ioctl_wait && !romcopy_start && !cart_loaded)
			else report_mismatch("loader outputs after reset");
		assert (!bk_load && !bk_save && !use_img && !pad_data_in && user_out == 7'h7F)
			else report_mismatch("backup or SNAC outputs after reset");
		assert (int'(video_arx) == `N64IO_AR_DEF_X && int'(video_ary) == `N64IO_AR_DEF_Y)
			else report_mismatch("ratio after reset");
		boot_rom_download();
		handheld_download();
		main_download();
		backup_triggers();
		aspect_table();
		snac_routing();
		if (cart_loaded) begin
			$display("TB PASSED");
			$finish;
		end else begin
			report_mismatch("cart_loaded dropped before reset");
		end
	end

endmodule

// File: n64_io.f
+incdir+logic
logic/n64_io_pkg.sv
logic/halfword_packer.sv
logic/ioctl_loader.sv
logic/backup_control.sv
logic/aspect_ratio_select.sv
logic/snac_port_mux.sv
logic/n64_io_top.sv
sim/n64_io_tb.sv

// File: Makefile
# Verilator flow for the console I/O glue
# Override on the command line, e.g. make sim SIM_DIR=build

TOP ?= n64_io_tb
RTL_TOP ?= n64_io_top
FILELIST ?= n64_io.f
SIM_DIR ?= obj_dir
VERILATOR ?= verilator
FLAGS ?= --x-assign unique --x-initial unique

COMMON = --assert --timing --timescale 1ns/1ns -f $(FILELIST)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(COMMON) $(FLAGS) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(COMMON) $(FLAGS) --top-module $(TOP)

# The testbench ends in $fatal on any failure, so the run sets the exit status
sim:
	$(VERILATOR) --binary $(COMMON) $(FLAGS) --top-module $(TOP) \
		--Mdir $(SIM_DIR) -o V$(TOP)
	./$(SIM_DIR)/V$(TOP)

clean:
	rm -rf $(SIM_DIR)
